/* build.f */
common/fetch_pkg.sv
fetch1/branch_predictor.sv
fetch1/pc_gen.sv
fetch2/fetch2_stage.sv
hdl/fetch_hazard_unit.sv
hdl/fetch_top.sv
testbench/tb_clock.sv
testbench/fetch_tb.sv

/* common/fetch_pkg.sv */
// ****************************************
// Shared types for the RV32 fetch front end.
// BUS_LITTLE selects the bus byte order for the whole design.
// Only one byte order is built at a time.
// ****************************************

package fetch_pkg;

  // Data and address word.
  typedef logic [31:0] word_t;

  // Program counter after reset.
  localparam word_t RESET_PC = 32'h0000_0000;

  // Branch target buffer geometry.
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  // Tag covers the pc bits above the index and the byte offset.
  localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

  // 1 when the bus delivers little-endian bytes.
  localparam logic BUS_LITTLE = 1'b1;

  // Branch prediction for one pc.
  typedef struct packed {
    logic  taken;
    word_t target;
  } prediction_t;

  // Request from fetch1 to fetch2.
  typedef struct packed {
    word_t       pc;
    prediction_t pred;
  } fetch_req_t;

  // Entry handed to decode.
  typedef struct packed {
    logic        valid;
    word_t       pc;
    word_t       pc4;
    word_t       instr;
    prediction_t pred;
    logic        mal_insn;
  } decode_slot_t;

  // Branch outcome from execute.
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t target;
    logic  taken;
    logic  mispredict;
  } resolve_t;

  // APB master outputs; reads only.
  typedef struct packed {
    logic  psel;
    logic  penable;
    word_t paddr;
  } apb_req_t;

  // APB master inputs.
  typedef struct packed {
    word_t prdata;
    logic  pready;
  } apb_rsp_t;

  // APB master states.
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } bus_state_e;

  // Pipeline control from the hazard unit.
  typedef struct packed {
    logic pc_en;
    logic stall;
    logic flush;
  } hazard_ctrl_t;

endpackage

/* fetch1/branch_predictor.sv */
// ****************************************
// Direct-mapped branch target buffer.
// Indexed by pc bits above bit 1.
// Every valid resolve writes its entry.
// Lookup sees the table before this cycle's write.
// ****************************************

`timescale 1ns/1ps

module branch_predictor (
  input  logic                   CLK,
  input  logic                   nRST,
  input  fetch_pkg::word_t       lookup_pc,
  input  fetch_pkg::resolve_t    resolve,
  output fetch_pkg::prediction_t pred
);
  import fetch_pkg::*;

  // Table storage.
  logic [BTB_ENTRIES-1:0] entry_valid;
  logic [BTB_TAG_W-1:0]   entry_tag    [BTB_ENTRIES];
  word_t                  entry_target [BTB_ENTRIES];
  logic                   entry_taken  [BTB_ENTRIES];

  // Lookup side.
  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic                 hit;

  // Update side.
  logic [BTB_IDX_W-1:0] wr_idx;
  logic [BTB_TAG_W-1:0] wr_tag;

  assign rd_idx = lookup_pc[BTB_IDX_W+1:2];
  assign rd_tag = lookup_pc[31:BTB_IDX_W+2];
  assign wr_idx = resolve.pc[BTB_IDX_W+1:2];
  assign wr_tag = resolve.pc[31:BTB_IDX_W+2];

  // Hit needs a valid entry with matching tag.
  assign hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);

  // Taken only on a hit whose last outcome was taken.
  assign pred.taken  = hit & entry_taken[rd_idx];
  assign pred.target = entry_target[rd_idx];

  // Valid bits start cleared.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      entry_valid <= '0;
    end else if (resolve.valid) begin
      entry_valid[wr_idx] <= 1'b1;
    end
  end

  // Entry contents.
  always_ff @(posedge CLK) begin
    if (resolve.valid) begin
      entry_tag[wr_idx]    <= wr_tag;
      entry_target[wr_idx] <= resolve.target;
      entry_taken[wr_idx]  <= resolve.taken;
    end
  end

endmodule

/* fetch1/pc_gen.sv */
// ****************************************
// Fetch1 program counter.
// Holds pc and its prediction for fetch2.
// Updates only on pc enable or flush.
// ****************************************

`timescale 1ns/1ps

module pc_gen (
  input  logic                   CLK,
  input  logic                   nRST,
  input  fetch_pkg::hazard_ctrl_t ctrl,
  input  fetch_pkg::resolve_t    resolve,
  input  fetch_pkg::prediction_t pred,
  output fetch_pkg::fetch_req_t  req,
  output fetch_pkg::word_t       lookup_pc
);
  import fetch_pkg::*;

  fetch_req_t req_q;
  word_t      next_pc;
  word_t      pc4;

  assign pc4 = req_q.pc + 32'd4;

  // Redirect first, then predicted target, then sequential.
  always_comb begin
    if (ctrl.flush) begin
      next_pc = resolve.target;
    end else if (req_q.pred.taken) begin
      next_pc = req_q.pred.target;
    end else begin
      next_pc = pc4;
    end
  end

  // BTB looks up the next pc so its prediction
  // is registered together with it.
  assign lookup_pc = next_pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      req_q.pc   <= RESET_PC;
      req_q.pred <= '0;
    end else if (ctrl.pc_en | ctrl.flush) begin
      req_q.pc   <= next_pc;
      req_q.pred <= pred;
    end
  end

  assign req = req_q;

endmodule

/* fetch2/fetch2_stage.sv */
// ****************************************
// Fetch2 stage and APB read master.
// One transfer at a time; APB cannot abort.
// Misaligned pc skips the bus, instr reads zero.
// Launches only when the slot is free or being taken.
// ****************************************

`timescale 1ns/1ps

module fetch2_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  fetch_pkg::fetch_req_t   req,
  input  fetch_pkg::hazard_ctrl_t ctrl,
  input  logic                    halt,
  input  logic                    decode_ready,
  input  fetch_pkg::apb_rsp_t     apb_rsp,
  output fetch_pkg::apb_req_t     apb_req,
  output fetch_pkg::decode_slot_t slot,
  output logic                    done,
  output logic                    busy,
  output logic                    slot_full
);
  import fetch_pkg::*;

  bus_state_e   state;
  bus_state_e   state_nxt;
  fetch_req_t   req_q;
  fetch_req_t   src;
  word_t        instr;
  logic         launch;
  logic         mal_addr;
  decode_slot_t entry;

  // New request may start only from IDLE.
  assign launch = (state == IDLE) && !halt && !ctrl.flush && !ctrl.stall;

  // In IDLE the request comes straight from fetch1.
  assign src      = (state == IDLE) ? req : req_q;
  assign mal_addr = (src.pc[1:0] != 2'b00);

  // Bus to core byte order.
  assign instr = BUS_LITTLE ?
                 {apb_rsp.prdata[7:0], apb_rsp.prdata[15:8],
                  apb_rsp.prdata[23:16], apb_rsp.prdata[31:24]} :
                 apb_rsp.prdata;

  // APB state machine.
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (launch && !mal_addr) begin
          state_nxt = SETUP;
        end
      end
      SETUP: state_nxt = ACCESS;
      ACCESS: begin
        // Back to IDLE, so no SETUP in the completing cycle.
        if (apb_rsp.pready) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Address and prediction held for the whole transfer.
  always_ff @(posedge CLK) begin
    if (launch && !mal_addr) begin
      req_q <= req;
    end
  end

  assign apb_req.psel    = (state != IDLE);
  assign apb_req.penable = (state == ACCESS);
  assign apb_req.paddr   = req_q.pc;

  // Status for the hazard unit.
  assign done = ((state == ACCESS) && apb_rsp.pready) || (launch && mal_addr);
  assign busy = (state != IDLE);

  // Entry built from the current request.
  always_comb begin
    entry.valid    = 1'b1;
    entry.pc       = src.pc;
    entry.pc4      = src.pc + 32'd4;
    entry.instr    = mal_addr ? '0 : instr;
    entry.pred     = src.pred;
    entry.mal_insn = mal_addr;
  end

  // Decode slot.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      slot <= '0;
    end else if (ctrl.flush || halt) begin
      slot.valid <= 1'b0;
    end else if (done && ctrl.pc_en) begin
      slot <= entry;
    end else if (slot.valid && decode_ready) begin
      // Taken by decode with nothing new behind it.
      slot.valid <= 1'b0;
    end
  end

  assign slot_full = slot.valid;

endmodule

/* hdl/fetch_hazard_unit.sv */
// ****************************************
// Fetch hazard control.
// Halt blocks pc advance; flush always redirects.
// A transfer open at flush or halt is dropped when it ends.
// ****************************************

`timescale 1ns/1ps

module fetch_hazard_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   halt,
  input  fetch_pkg::resolve_t    resolve,
  input  logic                   done,
  input  logic                   busy,
  input  logic                   slot_full,
  input  logic                   decode_ready,
  output fetch_pkg::hazard_ctrl_t ctrl
);

  logic flush_now;
  logic slot_blocked;
  logic drop_pend;

  // Mispredict from execute redirects now.
  assign flush_now = resolve.valid & resolve.mispredict;

  // Slot holds an entry that decode does not take.
  assign slot_blocked = slot_full & ~decode_ready;

  // Remember that the open transfer belongs to a dead path.
  // Cleared when that transfer completes.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      drop_pend <= 1'b0;
    end else if (done) begin
      drop_pend <= 1'b0;
    end else if ((flush_now | halt) & busy) begin
      drop_pend <= 1'b1;
    end
  end

  // Priority is halt, then flush, then stall.
  always_comb begin
    ctrl.flush = flush_now;
    ctrl.stall = 1'b0;
    ctrl.pc_en = 1'b0;
    if (halt) begin
      // Nothing advances while halted.
      ctrl.stall = 1'b0;
    end else if (flush_now) begin
      // Redirect only; completing data is thrown away.
      ctrl.stall = 1'b0;
    end else if (slot_blocked) begin
      ctrl.stall = 1'b1;
    end else begin
      // Dropped transfers never advance the pc.
      ctrl.pc_en = done & ~drop_pend;
    end
  end

endmodule

/* hdl/fetch_top.sv */
// ****************************************
// Fetch front end top level.
// Decode, execute and memory sit outside.
// The APB bus is read-only; pwrite is tied low externally.
// ****************************************

`timescale 1ns/1ps

module fetch_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   halt,
  input  fetch_pkg::resolve_t    resolve,
  input  fetch_pkg::apb_rsp_t    apb_rsp,
  input  logic                   decode_ready,
  output fetch_pkg::apb_req_t    apb_req,
  output fetch_pkg::decode_slot_t slot
);
  import fetch_pkg::*;

  // Stage to stage wiring.
  fetch_req_t   req;
  prediction_t  pred;
  word_t        lookup_pc;
  hazard_ctrl_t ctrl;

  // Status from fetch2 to the hazard unit.
  logic done;
  logic busy;
  logic slot_full;

  // Stall, flush and pc enable.
  fetch_hazard_unit i_hazard (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .resolve      (resolve),
    .done         (done),
    .busy         (busy),
    .slot_full    (slot_full),
    .decode_ready (decode_ready),
    .ctrl         (ctrl)
  );

  // First stage.
  pc_gen i_pc_gen (
    .CLK       (CLK),
    .nRST      (nRST),
    .ctrl      (ctrl),
    .resolve   (resolve),
    .pred      (pred),
    .req       (req),
    .lookup_pc (lookup_pc)
  );

  // Prediction for the next pc.
  branch_predictor i_btb (
    .CLK       (CLK),
    .nRST      (nRST),
    .lookup_pc (lookup_pc),
    .resolve   (resolve),
    .pred      (pred)
  );

  // Second stage and bus master.
  fetch2_stage i_fetch2 (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (req),
    .ctrl         (ctrl),
    .halt         (halt),
    .decode_ready (decode_ready),
    .apb_rsp      (apb_rsp),
    .apb_req      (apb_req),
    .slot         (slot),
    .done         (done),
    .busy         (busy),
    .slot_full    (slot_full)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the fetch front end testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module fetch_tb --Mdir obj_dir -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

/* testbench/fetch_tb.sv */
// ****************************************
// Fetch front end testbench with random stimulus.
// Models APB memory, decode and execute around the DUT.
// Memory covers 256 words; higher addresses wrap.
// ****************************************

`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  // Test lengths in accepted instructions.
  localparam int LEN_SEQ   = 40;
  localparam int LEN_BP    = 60;
  localparam int LEN_REDIR = 80;
  localparam int LEN_PRED  = 80;
  localparam int LEN_MAL   = 20;
  localparam int CYCLE_LIMIT = 2 * (LEN_SEQ + LEN_BP + LEN_REDIR + LEN_PRED + LEN_MAL) * 8;

  logic         CLK;
  logic         nRST;
  logic         halt;
  resolve_t     resolve;
  apb_rsp_t     apb_rsp;
  logic         decode_ready;
  apb_req_t     apb_req;
  decode_slot_t slot;

  // Memory image and BTB model.
  word_t                mem      [256];
  logic                 m_valid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] m_tag    [BTB_ENTRIES];
  word_t                m_target [BTB_ENTRIES];
  logic                 m_taken  [BTB_ENTRIES];

  // Entry as it was before the last model write.
  logic [BTB_IDX_W-1:0] o_idx;
  logic                 o_valid;
  logic [BTB_TAG_W-1:0] o_tag;
  word_t                o_target;
  logic                 o_taken;

  // Reference state and counters.
  logic [31:0] rng;
  word_t       exp_pc;
  int          skip_pred;
  int          items;
  int          setups;
  int          errors;
  int          checks;
  int          cycles;
  int          pred_hits;
  int          flushes;
  int          failed_tests;
  int          base;

  // Stimulus mode.
  int          ready_mode;
  logic [3:0]  res_pct;
  logic [3:0]  taken_pct;
  logic [7:0]  tgt_mask;
  logic        halt_on;
  logic        redir_req;
  word_t       redir_tgt;

  // Values seen in the previous cycle.
  apb_req_t     prev_req;
  logic         prev_pready;
  logic         prev_blocked;
  logic         prev_halt;
  logic         prev_flush;
  decode_slot_t prev_slot;
  logic [1:0]   wait_cnt;

  tb_clock i_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  fetch_top i_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .resolve      (resolve),
    .apb_rsp      (apb_rsp),
    .decode_ready (decode_ready),
    .apb_req      (apb_req),
    .slot         (slot)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bus word to core byte order.
  function automatic word_t to_core(input word_t w);
    if (BUS_LITTLE) begin
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return w;
  endfunction

  // Prediction from one BTB entry; target only counts when taken.
  function automatic prediction_t btb_lookup(input logic v, input logic [BTB_TAG_W-1:0] t,
                                             input word_t tgt, input logic tk,
                                             input logic [BTB_TAG_W-1:0] tag);
    prediction_t p;
    p.taken  = v && (t == tag) && tk;
    p.target = p.taken ? tgt : '0;
    return p;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_slot(input string name, input decode_slot_t got,
                            input decode_slot_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_apb(input string name, input apb_req_t got, input apb_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic btb_write(input word_t pc, input word_t tgt, input logic tk);
    logic [BTB_IDX_W-1:0] i;
    i = pc[BTB_IDX_W+1:2];
    o_idx    = i;
    o_valid  = m_valid[i];
    o_tag    = m_tag[i];
    o_target = m_target[i];
    o_taken  = m_taken[i];
    m_valid[i]  = 1'b1;
    m_tag[i]    = pc[31:BTB_IDX_W+2];
    m_target[i] = tgt;
    m_taken[i]  = tk;
  endtask

  // One clock cycle: sample at the falling edge, drive at the rising edge.
  task automatic step();
    apb_req_t     exp_req;
    decode_slot_t exp;
    decode_slot_t got;
    prediction_t  old_pred;
    resolve_t     nx_res;
    logic         nx_ready;
    logic         nx_pready;
    word_t        nx_prdata;
    logic         force_low;
    logic         res_taken;
    word_t        res_tgt;
    logic [BTB_IDX_W-1:0] idx;
    logic [BTB_TAG_W-1:0] tag;
    @(negedge CLK);
    nx_res    = '0;
    force_low = 1'b0;
    rng = xorshift(rng);

    // APB protocol.
    exp_req = apb_req;
    if (prev_req.psel && (!prev_req.penable || !prev_pready)) begin
      exp_req = '{psel: 1'b1, penable: 1'b1, paddr: prev_req.paddr};
      check_apb("apb_req", apb_req, exp_req);
    end else if ((prev_req.psel && prev_pready) || prev_blocked || prev_halt || prev_flush) begin
      // No SETUP may open here.
      exp_req.psel    = 1'b0;
      exp_req.penable = 1'b0;
      check_apb("apb_req", apb_req, exp_req);
    end else if (apb_req.psel) begin
      exp_req.penable = 1'b0;
      check_apb("apb_req", apb_req, exp_req);
    end
    if (apb_req.psel && !apb_req.penable) begin
      setups++;
    end

    // Memory answers after 0 to 3 wait cycles.
    if (apb_req.psel && !apb_req.penable) begin
      wait_cnt = rng[1:0];
    end else if (apb_req.psel && !apb_rsp.pready && wait_cnt != 2'd0) begin
      wait_cnt = wait_cnt - 2'd1;
    end
    nx_pready = apb_req.psel && !(apb_req.penable && apb_rsp.pready) && (wait_cnt == 2'd0);
    nx_prdata = nx_pready ? mem[apb_req.paddr[9:2]] : rng;

    // Slot must hold under back-pressure.
    if (prev_blocked && !prev_halt && !prev_flush) begin
      check_slot("slot hold", slot, prev_slot);
    end
    if (prev_halt) begin
      check_word("slot.valid while halted", {31'b0, slot.valid}, 32'd0);
    end

    // Decode takes the slot.
    if (slot.valid && decode_ready) begin
      idx = exp_pc[BTB_IDX_W+1:2];
      tag = exp_pc[31:BTB_IDX_W+2];
      // Target only matters for a taken prediction.
      got = slot;
      if (!got.pred.taken) begin
        got.pred.target = '0;
      end
      exp.valid    = 1'b1;
      exp.pc       = exp_pc;
      exp.pc4      = exp_pc + 32'd4;
      exp.mal_insn = (exp_pc[1:0] != 2'b00);
      exp.instr    = exp.mal_insn ? 32'd0 : to_core(mem[exp_pc[9:2]]);
      exp.pred     = btb_lookup(m_valid[idx], m_tag[idx], m_target[idx], m_taken[idx], tag);
      if (skip_pred != 0) begin
        // Looked up before the last write reached the table.
        old_pred = btb_lookup(o_valid, o_tag, o_target, o_taken, tag);
        if (idx == o_idx && got.pred == old_pred) begin
          exp.pred = old_pred;
        end
        skip_pred--;
      end
      if (exp.pred.taken) begin
        pred_hits++;
      end
      check_slot("slot", got, exp);
      items++;
      exp_pc = exp.pred.taken ? exp.pred.target : exp_pc + 32'd4;

      // Execute resolves some of the accepted branches.
      // One table write outstanding at a time.
      if (!redir_req && skip_pred == 0 && res_pct != 4'd0 && rng[7:4] < res_pct) begin
        res_taken = rng[11:8] < taken_pct;
        res_tgt   = res_taken ? {22'd0, rng[21:14] & tgt_mask, 2'b00} : slot.pc + 32'd4;
        nx_res.valid      = 1'b1;
        nx_res.pc         = slot.pc;
        nx_res.target     = res_tgt;
        nx_res.taken      = res_taken;
        nx_res.mispredict = (res_taken != slot.pred.taken) ||
                            (res_taken && res_tgt != slot.pred.target);
        btb_write(slot.pc, res_tgt, res_taken);
        exp_pc    = res_tgt;
        force_low = 1'b1;
        // Items already looked up saw the old table.
        if (nx_res.mispredict) begin
          skip_pred = 1;
          flushes++;
        end else if (skip_pred < 3) begin
          skip_pred = 3;
        end
      end
    end

    // Directed redirect from execute.
    if (redir_req) begin
      nx_res = '{valid: 1'b1, pc: 32'h0000_2000, target: redir_tgt,
                 taken: 1'b0, mispredict: 1'b1};
      btb_write(32'h0000_2000, redir_tgt, 1'b0);
      exp_pc    = redir_tgt;
      skip_pred = 1;
      force_low = 1'b1;
      redir_req = 1'b0;
    end

    nx_ready = !force_low && ((ready_mode == 0) || (ready_mode == 1 && rng[24]));
    prev_req     = apb_req;
    prev_pready  = apb_rsp.pready;
    prev_blocked = slot.valid && !decode_ready;
    prev_halt    = halt;
    prev_flush   = resolve.valid && resolve.mispredict;
    prev_slot    = slot;

    @(posedge CLK);
    decode_ready <= nx_ready;
    halt         <= halt_on;
    resolve      <= nx_res;
    apb_rsp      <= '{prdata: nx_prdata, pready: nx_pready};
  endtask

  task automatic run_items(input int n);
    int target;
    target = items + n;
    while (items < target) begin
      step();
    end
  endtask

  task automatic report(input int num, input string name, input int err0, input int n0);
    if (errors == err0) begin
      $display("Test %0d %s: PASS, %0d items", num, name, items - n0);
    end else begin
      failed_tests++;
      $display("Test %0d %s: FAIL, %0d errors", num, name, errors - err0);
    end
  endtask

  task automatic random_test(input int num, input string name, input int len,
                             input logic [3:0] rp, input logic [3:0] tp, input logic [7:0] tm);
    int e0;
    int n0;
    int f0;
    int h0;
    e0 = errors;
    n0 = items;
    f0 = flushes;
    h0 = pred_hits;
    res_pct   = rp;
    taken_pct = tp;
    tgt_mask  = tm;
    run_items(len);
    if (num == 3 && flushes == f0) begin
      errors++;
      $display("No mispredict redirect happened in the redirect test");
    end
    if (num == 4 && pred_hits == h0) begin
      errors++;
      $display("No taken prediction was checked in the prediction test");
    end
    report(num, name, e0, n0);
  endtask

  task automatic mal_halt_test();
    int e0;
    int n0;
    e0 = errors;
    n0 = items;
    ready_mode = 0;
    res_pct    = 4'd0;
    // Misaligned target never reaches the bus.
    redir_tgt = 32'h0001_0002;
    redir_req = 1'b1;
    step();
    step();
    base = setups;
    run_items(8);
    check_word("bus reads during misaligned fetch", word_t'(setups), word_t'(base));
    redir_tgt = 32'h0000_0100;
    redir_req = 1'b1;
    run_items(4);
    // Halt with a transfer possibly open.
    ready_mode = 1;
    halt_on    = 1'b1;
    step();
    step();
    base = setups;
    repeat (10) step();
    check_word("bus reads while halted", word_t'(setups), word_t'(base));
    halt_on   = 1'b0;
    redir_tgt = 32'h0000_0040;
    redir_req = 1'b1;
    run_items(8);
    report(5, "misaligned and halt", e0, n0);
  endtask

  // Hard limit on the run length.
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped delivering instructions", cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    halt         = 1'b0;
    resolve      = '0;
    apb_rsp      = '0;
    decode_ready = 1'b0;
    rng          = 32'h336ac0ee;
    exp_pc       = RESET_PC;
    skip_pred    = 0;
    items        = 0;
    setups       = 0;
    errors       = 0;
    checks       = 0;
    pred_hits    = 0;
    flushes      = 0;
    failed_tests = 0;
    ready_mode   = 0;
    res_pct      = 4'd0;
    taken_pct    = 4'd0;
    tgt_mask     = 8'hff;
    halt_on      = 1'b0;
    redir_req    = 1'b0;
    redir_tgt    = '0;
    prev_req     = '0;
    prev_pready  = 1'b0;
    prev_blocked = 1'b0;
    prev_halt    = 1'b0;
    prev_flush   = 1'b0;
    prev_slot    = '0;
    wait_cnt     = 2'd0;
    o_idx        = '0;
    o_valid      = 1'b0;
    for (int i = 0; i < 256; i++) begin
      rng    = xorshift(rng);
      mem[i] = rng;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
    wait (nRST == 1'b1);

    random_test(1, "sequential fetch", LEN_SEQ, 4'd0, 4'd0, 8'hff);
    ready_mode = 1;
    random_test(2, "back-pressure", LEN_BP, 4'd0, 4'd0, 8'hff);
    random_test(3, "redirect", LEN_REDIR, 4'd4, 4'd8, 8'hff);
    random_test(4, "prediction", LEN_PRED, 4'd5, 4'd14, 8'h1f);
    mal_halt_test();

    $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors, %0d cycles",
             failed_tests, checks, errors, cycles);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* testbench/tb_clock.sv */
// ****************************************
// Testbench clock and reset source.
// 4 ns period; nRST held low for 5 cycles.
// ****************************************

`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic nRST
);

  // Free running clock.
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Reset released on a rising edge.
  initial begin
    nRST = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
  end

endmodule
